//--- hw/irq_pkg.sv
package irq_pkg;

   // ==============================
   // Interrupt line types
   // ==============================

   typedef logic [2:0] irq_id_t;             // Line number, enough for eight lines

   // ==============================
   // Pipeline flush
   // ==============================

   // Bit order from 0 is fetch, decode_0, decode_1, register, address, execute, writeback
   typedef logic [6:0] flush_t;

   localparam flush_t FLUSH_ALL = 7'h7F;     // Every stage drops its contents

   // ==============================
   // Interrupt entry FSM
   // ==============================

   typedef enum logic [3:0] {
      IDLE, FLUSH, HANDSHAKE, SAVE, RD_OFF,
      WAIT_OFF, RD_CS, WAIT_CS, LOAD, RELEASE
   } int_state_t;

endpackage

//--- hw/cpu_mem_pkg.sv
package cpu_mem_pkg;

   // ==============================
   // Memory port types
   // ==============================

   typedef logic [31:0] addr_t;              // Byte address on the memory port

   typedef logic [31:0] data_t;              // One data word on either phase

   typedef logic [3:0] wr_size_t;            // One enable per byte lane of a write

   // ==============================
   // Segment registers
   // ==============================

   typedef logic [15:0] seg_t;               // Selector loaded into CS

   // Each vector table entry is two words wide
   localparam addr_t IDT_ENTRY_BYTES = 32'd8;

   localparam addr_t WORD_BYTES = 32'd4;     // Step from offset word to CS word

endpackage

//--- hw/irq_sel_if.sv
`timescale 1ns/1ns

interface irq_sel_if;

   import irq_pkg::*;

   logic    pending;                         // Some cell holds a request
   irq_id_t id;                              // Lowest pending line
   logic    clear;                           // Pulses for one cycle in LOAD
   irq_id_t clear_id;                        // Line served by the current entry

   // Selector side
   modport sel (
      output pending,
      output id,
      input  clear,
      input  clear_id
   );

   // Controller side
   modport ctrl (
      input  pending,
      input  id,
      output clear,
      output clear_id
   );

endinterface

//--- hw/irq_edge_sync.sv
`timescale 1ns/1ns

module irq_edge_sync #(
   parameter int NUM_IRQ = 8
) (
   input  logic               clk,
   input  logic               arst_n,
   input  logic [NUM_IRQ-1:0] irq_lines,
   output logic [NUM_IRQ-1:0] edge_pulse
);

   logic [NUM_IRQ-1:0] sync_0;               // First stage may go metastable
   logic [NUM_IRQ-1:0] sync_1;
   logic [NUM_IRQ-1:0] sync_dly;             // Previous value of the clean line

   // ==============================
   // Two-flop synchronizer
   // ==============================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_0 <= '0;
         sync_1 <= '0;
      end else begin
         sync_0 <= irq_lines;
         sync_1 <= sync_0;
      end
   end

   // Rising edge is registered so the pulse lands three cycles after the line
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_dly   <= '0;
         edge_pulse <= '0;
      end else begin
         sync_dly   <= sync_1;
         edge_pulse <= sync_1 & ~sync_dly;
      end
   end

endmodule

//--- hw/irq_pending_cell.sv
`timescale 1ns/1ns

module irq_pending_cell (
   input  logic clk,
   input  logic arst_n,
   input  logic set,
   input  logic clr,
   output logic pending
);

   logic flag;

   // ==============================
   // Sticky request flag
   // ==============================

   // A new edge in the clear cycle must survive, so set is tested first
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flag <= 1'b0;
      end else if (set) begin
         flag <= 1'b1;
      end else if (clr) begin
         flag <= 1'b0;
      end
   end

   assign pending = flag;                    // Seen by the selector one edge after the pulse

endmodule

//--- hw/irq_priority.sv
`timescale 1ns/1ns

module irq_priority #(
   parameter int NUM_IRQ = 8
) (
   input  logic [NUM_IRQ-1:0] cell_pending,
   output logic [NUM_IRQ-1:0] cell_clr,
   irq_sel_if.sel             sel
);

   import irq_pkg::*;

   // ==============================
   // Lowest index wins
   // ==============================

   always_comb begin
      sel.id = '0;
      // Scan downward so the last hit is the lowest pending line
      for (int i = NUM_IRQ - 1; i >= 0; i--) begin
         if (cell_pending[i]) begin
            sel.id = irq_id_t'(i);
         end
      end
   end

   assign sel.pending = |cell_pending;       // Any cell asks for service

   // ==============================
   // Clear decode
   // ==============================

   always_comb begin
      cell_clr = '0;
      for (int i = 0; i < NUM_IRQ; i++) begin
         // The controller names the line it latched, not the current winner
         if (sel.clear && (sel.clear_id == irq_id_t'(i))) begin
            cell_clr[i] = 1'b1;
         end
      end
   end

endmodule

//--- hw/int_controller.sv
`timescale 1ns/1ns

module int_controller #(
   parameter cpu_mem_pkg::addr_t IDT_BASE   = 32'h0000_0400,
   parameter cpu_mem_pkg::addr_t STACK_ADDR = 32'h0000_7FFC
) (
   input  logic                  clk,
   input  logic                  arst_n,
   irq_sel_if.ctrl               sel,
   output logic                  mem_valid,
   input  logic                  mem_ready,
   output cpu_mem_pkg::addr_t    mem_address,
   output logic                  mem_wr_en,
   output cpu_mem_pkg::data_t    mem_wr_data,
   output cpu_mem_pkg::wr_size_t mem_wr_size,
   input  logic                  mem_dp_valid,
   input  cpu_mem_pkg::data_t    mem_dp_read_data,
   output irq_pkg::flush_t       flush,
   output logic                  decode_start_int,
   input  logic                  decode_end_int,
   output logic                  capture_bottom_eip,
   input  cpu_mem_pkg::addr_t    return_eip,
   output logic                  fetch_load,
   output cpu_mem_pkg::addr_t    fetch_load_address,
   output logic                  reg_load_cs,
   output cpu_mem_pkg::seg_t     reg_cs
);

   import irq_pkg::*;
   import cpu_mem_pkg::*;

   int_state_t state_q;
   int_state_t state_d;

   irq_id_t id_q;                            // Line taken at the start of the entry
   addr_t   eip_q;                           // Return address bound for the stack slot
   addr_t   off_q;                           // Handler offset from the first vector word
   seg_t    cs_q;                            // Handler code segment
   addr_t   vec_addr;

   assign vec_addr = IDT_BASE + (addr_t'(id_q) * IDT_ENTRY_BYTES);

   // ==============================
   // Next state
   // ==============================

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:      if (sel.pending) state_d = FLUSH;
         FLUSH:     state_d = HANDSHAKE;
         HANDSHAKE: if (decode_end_int) state_d = SAVE;
         SAVE:      if (mem_ready) state_d = RD_OFF;
         RD_OFF:    if (mem_ready) state_d = WAIT_OFF;
         WAIT_OFF:  if (mem_dp_valid) state_d = RD_CS;
         RD_CS:     if (mem_ready) state_d = WAIT_CS;
         WAIT_CS:   if (mem_dp_valid) state_d = LOAD;
         LOAD:      state_d = RELEASE;
         RELEASE:   if (!decode_end_int) state_d = IDLE;  // Decode has closed the exchange
         default:   state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ==============================
   // Entry payload
   // ==============================

   always_ff @(posedge clk) begin
      if (state_q == IDLE && sel.pending) begin
         id_q <= sel.id;
      end
      if (state_q == FLUSH) begin
         eip_q <= return_eip;                // Fetch presents the bottom EIP in this cycle
      end
      if (state_q == WAIT_OFF && mem_dp_valid) begin
         off_q <= mem_dp_read_data;
      end
      if (state_q == WAIT_CS && mem_dp_valid) begin
         cs_q <= mem_dp_read_data[15:0];
      end
   end

   // ==============================
   // Outputs
   // ==============================

   // Start stays up through LOAD so decode keeps its ack high until the load
   assign decode_start_int = !(state_q inside {IDLE, FLUSH, RELEASE});

   assign flush              = (state_q == FLUSH) ? FLUSH_ALL : '0;
   assign capture_bottom_eip = (state_q == FLUSH);

   assign mem_valid   = state_q inside {SAVE, RD_OFF, RD_CS};
   assign mem_wr_en   = (state_q == SAVE);
   assign mem_wr_size = (state_q == SAVE) ? 4'hF : 4'h0;
   assign mem_wr_data = eip_q;

   always_comb begin
      case (state_q)
         SAVE:             mem_address = STACK_ADDR;
         RD_OFF, WAIT_OFF: mem_address = vec_addr;
         RD_CS, WAIT_CS:   mem_address = vec_addr + WORD_BYTES;  // CS word follows the offset
         default:          mem_address = '0;
      endcase
   end

   assign fetch_load         = (state_q == LOAD);
   assign reg_load_cs        = (state_q == LOAD);
   assign fetch_load_address = off_q;
   assign reg_cs             = cs_q;

   assign sel.clear    = (state_q == LOAD);  // Cell drops on the same edge as the load
   assign sel.clear_id = id_q;

endmodule

//--- hw/int_subsystem.sv
`timescale 1ns/1ns

module int_subsystem #(
   parameter int                 NUM_IRQ    = 8,
   parameter cpu_mem_pkg::addr_t IDT_BASE   = 32'h0000_0400,
   parameter cpu_mem_pkg::addr_t STACK_ADDR = 32'h0000_7FFC
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [NUM_IRQ-1:0]    irq_lines,
   output logic                  mem_valid,
   input  logic                  mem_ready,
   output cpu_mem_pkg::addr_t    mem_address,
   output logic                  mem_wr_en,
   output cpu_mem_pkg::data_t    mem_wr_data,
   output cpu_mem_pkg::wr_size_t mem_wr_size,
   input  logic                  mem_dp_valid,
   input  cpu_mem_pkg::data_t    mem_dp_read_data,
   output irq_pkg::flush_t       flush,
   output logic                  decode_start_int,
   input  logic                  decode_end_int,
   output logic                  capture_bottom_eip,
   input  cpu_mem_pkg::addr_t    return_eip,
   output logic                  fetch_load,
   output cpu_mem_pkg::addr_t    fetch_load_address,
   output logic                  reg_load_cs,
   output cpu_mem_pkg::seg_t     reg_cs
);

   logic [NUM_IRQ-1:0] edge_pulse;
   logic [NUM_IRQ-1:0] cell_pending;
   logic [NUM_IRQ-1:0] cell_clr;

   irq_sel_if u_sel_if ();

   // ==============================
   // Request side
   // ==============================

   irq_edge_sync #(.NUM_IRQ(NUM_IRQ)) u_edge_sync (
      .clk        (clk),
      .arst_n     (arst_n),
      .irq_lines  (irq_lines),
      .edge_pulse (edge_pulse)
   );

   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_cell
      irq_pending_cell u_cell (
         .clk     (clk),
         .arst_n  (arst_n),
         .set     (edge_pulse[i]),
         .clr     (cell_clr[i]),
         .pending (cell_pending[i])
      );
   end

   irq_priority #(.NUM_IRQ(NUM_IRQ)) u_priority (
      .cell_pending (cell_pending),
      .cell_clr     (cell_clr),
      .sel          (u_sel_if)
   );

   // ==============================
   // Entry sequencer
   // ==============================

   int_controller #(.IDT_BASE(IDT_BASE), .STACK_ADDR(STACK_ADDR)) u_controller (
      .clk                (clk),
      .arst_n             (arst_n),
      .sel                (u_sel_if),
      .mem_valid          (mem_valid),
      .mem_ready          (mem_ready),
      .mem_address        (mem_address),
      .mem_wr_en          (mem_wr_en),
      .mem_wr_data        (mem_wr_data),
      .mem_wr_size        (mem_wr_size),
      .mem_dp_valid       (mem_dp_valid),
      .mem_dp_read_data   (mem_dp_read_data),
      .flush              (flush),
      .decode_start_int   (decode_start_int),
      .decode_end_int     (decode_end_int),
      .capture_bottom_eip (capture_bottom_eip),
      .return_eip         (return_eip),
      .fetch_load         (fetch_load),
      .fetch_load_address (fetch_load_address),
      .reg_load_cs        (reg_load_cs),
      .reg_cs             (reg_cs)
   );

endmodule

//--- dv/int_subsystem_sva.sv
`timescale 1ns/1ns

module int_subsystem_sva (
   input logic               clk,
   input logic               arst_n,
   input logic               mem_valid,
   input logic               mem_ready,
   input cpu_mem_pkg::addr_t mem_address,
   input irq_pkg::flush_t    flush,
   input logic               decode_start_int,
   input logic               decode_end_int,
   input logic               fetch_load
);

   logic entry_open;                         // High from the flush until the load of that entry

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         entry_open <= 1'b0;
      end else if (flush != '0) begin
         entry_open <= 1'b1;
      end else if (fetch_load) begin
         entry_open <= 1'b0;
      end
   end

   // ==============================
   // Memory request handshake
   // ==============================

   a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_address))
      else $error("memory request dropped or changed before mem_ready");

   // ==============================
   // Decode handshake and flush
   // ==============================

   // Start may only drop once decode has acknowledged
   a_start_fall: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(decode_start_int) |-> $past(decode_end_int))
      else $error("decode_start_int fell before decode_end_int was high");

   // A stretched flush or a second flush inside one entry both land here
   a_flush_once: assert property (@(posedge clk) disable iff (!arst_n)
      (flush != '0) |-> !entry_open)
      else $error("flush high again before the entry ended with fetch_load");

   a_load_flushed: assert property (@(posedge clk) disable iff (!arst_n)
      fetch_load |-> entry_open)
      else $error("fetch_load without a flush earlier in the same entry");

   a_load_acked: assert property (@(posedge clk) disable iff (!arst_n)
      fetch_load |-> decode_end_int)
      else $error("fetch_load high while decode_end_int is low");

endmodule

//--- dv/int_subsystem_tb.sv
`timescale 1ns/1ns

module int_subsystem_tb;

   localparam int          NUM_IRQ      = 8;
   localparam logic [31:0] IDT_BASE     = 32'h0000_0400;
   localparam logic [31:0] STACK_ADDR   = 32'h0000_7FFC;
   localparam int          CLK_PERIOD   = 20;
   localparam int          DRIVE_DELAY  = 2;
   localparam int          QUIET_CYCLES = 40;
   localparam int          NUM_ROWS     = 6;

   // ==============================
   // Stimulus table
   // ==============================

   // Served ids are read from the sequence word starting at the lowest nibble
   localparam logic [7:0]  ROW_MASK  [NUM_ROWS] = '{8'h08, 8'h01, 8'hA6, 8'hFF, 8'h50, 8'h80};
   localparam logic [7:0]  ROW_LATE  [NUM_ROWS] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h02, 8'h08};
   localparam bit          ROW_STALL [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
   localparam int          ROW_CNT   [NUM_ROWS] = '{1, 1, 4, 8, 3, 2};
   localparam logic [31:0] ROW_SEQ   [NUM_ROWS] = '{32'h3, 32'h0, 32'h7521, 32'h7654_3210,
                                                    32'h614, 32'h37};

   logic clk, arst_n;
   logic [NUM_IRQ-1:0] irq_lines;
   logic mem_valid, mem_ready, mem_wr_en, mem_dp_valid;
   logic [31:0] mem_address, mem_wr_data, mem_dp_read_data;
   logic [3:0] mem_wr_size;
   logic [6:0] flush;
   logic decode_start_int, decode_end_int, capture_bottom_eip;
   logic [31:0] return_eip, fetch_load_address;
   logic fetch_load, reg_load_cs;
   logic [15:0] reg_cs;

   int cur_exp[$];                           // Expected ids of the running row
   int served[$];                            // Every id the DUT has loaded so far
   int row_base;
   bit stall;
   int main_errs;
   int mon_errs;
   integer seed = 32'h394;

   int_subsystem #(.NUM_IRQ(NUM_IRQ), .IDT_BASE(IDT_BASE), .STACK_ADDR(STACK_ADDR))
   u_int_subsystem (.*);

   bind int_subsystem int_subsystem_sva u_sva (
      .clk              (clk),
      .arst_n           (arst_n),
      .mem_valid        (mem_valid),
      .mem_ready        (mem_ready),
      .mem_address      (mem_address),
      .flush            (flush),
      .decode_start_int (decode_start_int),
      .decode_end_int   (decode_end_int),
      .fetch_load       (fetch_load)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic bit value_ok(string name, logic [31:0] got, logic [31:0] exp);
      bit ok;
      ok = (got === exp);
      assert (ok) else $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      return ok;
   endfunction

   task automatic pulse_lines(input logic [NUM_IRQ-1:0] mask);
      @(posedge clk);
      #DRIVE_DELAY;
      irq_lines = mask;
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      irq_lines = '0;
   endtask

   // ==============================
   // Memory and decode models, entry monitor
   // ==============================

   initial begin : model_loop
      logic [31:0] vec_mem [logic [31:0]];
      logic [31:0] rnd;
      logic [31:0] rd_data;
      logic [31:0] eip_cap;
      bit rd_pending;
      bit s_start;
      int rd_wait;
      int dec_cnt;
      int req_idx;
      int pos;
      int exp_id;
      for (int i = 0; i < NUM_IRQ; i++) begin
         vec_mem[IDT_BASE + 32'(8 * i)]     = 32'h1000_0000 + 32'(i);
         vec_mem[IDT_BASE + 32'(8 * i + 4)] = {16'hC0DE, 16'h0100 + 16'(i)};  // Upper half is junk
      end
      mem_ready = 1'b0;
      mem_dp_valid = 1'b0;
      mem_dp_read_data = 32'hDEAD_BEEF;
      decode_end_int = 1'b0;
      return_eip = 32'h0000_3000;
      rd_pending = 1'b0;
      rd_wait = 0;
      dec_cnt = -1;
      req_idx = 0;
      eip_cap = '0;
      forever begin
         @(negedge clk);
         s_start = decode_start_int;
         pos = served.size() - row_base;
         exp_id = (pos < cur_exp.size()) ? cur_exp[pos] : 0;
         if (arst_n && capture_bottom_eip) begin
            eip_cap = return_eip;
            req_idx = 0;
            if (!value_ok("flush", 32'(flush), 32'h0000_007F)) mon_errs++;
         end
         if (arst_n && mem_valid && mem_ready) begin
            case (req_idx)
               0: begin
                  if (!value_ok("mem_wr_en", 32'(mem_wr_en), 32'h1)) mon_errs++;
                  if (!value_ok("mem_address", mem_address, STACK_ADDR)) mon_errs++;
                  if (!value_ok("mem_wr_size", 32'(mem_wr_size), 32'hF)) mon_errs++;
                  if (!value_ok("mem_wr_data", mem_wr_data, eip_cap)) mon_errs++;
               end
               1, 2: begin
                  if (!value_ok("mem_wr_en", 32'(mem_wr_en), 32'h0)) mon_errs++;
                  if (!value_ok("mem_address", mem_address,
                                IDT_BASE + 32'(8 * exp_id + 4 * (req_idx - 1)))) mon_errs++;
               end
               default: begin
                  assert (0) else $display("extra memory request in one entry at %0t", $time);
                  mon_errs++;
               end
            endcase
            req_idx++;
            if (!mem_wr_en) begin
               assert (!rd_pending) else begin
                  $display("second read issued before the first returned at %0t", $time);
                  mon_errs++;
               end
               rnd = $random(seed);
               rd_pending = 1'b1;
               rd_wait = stall ? int'(rnd[1:0]) : 0;  // Up to three extra cycles of latency
               rd_data = vec_mem.exists(mem_address) ? vec_mem[mem_address] : 32'hBAD0_0000;
            end
         end
         if (arst_n && fetch_load) begin
            assert (pos < cur_exp.size()) else begin
               $display("unexpected extra entry at %0t", $time);
               mon_errs++;
            end
            if (!value_ok("reg_load_cs", 32'(reg_load_cs), 32'h1)) mon_errs++;
            if (!value_ok("fetch_load_address", fetch_load_address,
                          32'h1000_0000 + 32'(exp_id))) mon_errs++;
            if (!value_ok("reg_cs", 32'(reg_cs), 32'h0000_0100 + 32'(exp_id))) mon_errs++;
            served.push_back(int'(fetch_load_address - 32'h1000_0000));
         end
         @(posedge clk);
         #DRIVE_DELAY;
         rnd = $random(seed);
         return_eip = return_eip + 32'd4;
         mem_ready = stall ? rnd[0] : 1'b1;
         if (rd_pending && rd_wait == 0) begin
            mem_dp_valid = 1'b1;
            mem_dp_read_data = rd_data;
            rd_pending = 1'b0;
         end else begin
            if (rd_pending) rd_wait--;
            mem_dp_valid = 1'b0;
            mem_dp_read_data = 32'hDEAD_BEEF;
         end
         if (arst_n && s_start && !decode_end_int) begin
            if (dec_cnt < 0) dec_cnt = int'(rnd[3:2] % 2'd3);  // Ack after 1 to 3 cycles
            if (dec_cnt == 0) begin
               decode_end_int = 1'b1;
               dec_cnt = -1;
            end else begin
               dec_cnt--;
            end
         end else if (!s_start && decode_end_int) begin
            decode_end_int = 1'b0;
         end
      end
   end

   // ==============================
   // Test sequence
   // ==============================

   initial begin : main_seq
      logic [5:0] ctrl;
      int errs_before;
      int got_cnt;
      int failed;
      irq_lines = '0;
      arst_n = 1'b0;
      stall = 1'b0;
      row_base = 0;
      failed = 0;
      repeat (4) @(posedge clk);
      #DRIVE_DELAY;
      arst_n = 1'b1;
      for (int c = 0; c < 6; c++) begin
         @(negedge clk);
         ctrl = {mem_valid, decode_start_int, fetch_load, reg_load_cs, capture_bottom_eip, |flush};
         if (!value_ok("control outputs", 32'(ctrl), 32'h0)) main_errs++;
      end
      $display("idle after reset: %0s", (main_errs == 0) ? "ok" : "FAILED");
      if (main_errs != 0) failed++;
      for (int r = 0; r < NUM_ROWS; r++) begin
         errs_before = main_errs + mon_errs;
         cur_exp.delete();
         for (int k = 0; k < ROW_CNT[r]; k++) cur_exp.push_back(int'(ROW_SEQ[r][4*k +: 4]));
         row_base = served.size();
         stall = ROW_STALL[r];
         pulse_lines(ROW_MASK[r]);
         if (ROW_LATE[r] != '0) begin
            do @(negedge clk); while (!capture_bottom_eip);  // Late edge lands inside the entry
            pulse_lines(ROW_LATE[r]);
         end
         while (served.size() - row_base < ROW_CNT[r]) @(negedge clk);
         repeat (QUIET_CYCLES) @(negedge clk);
         got_cnt = served.size() - row_base;
         if (!value_ok("served count", 32'(got_cnt), 32'(ROW_CNT[r]))) main_errs++;
         for (int k = 0; k < got_cnt && k < ROW_CNT[r]; k++) begin
            if (!value_ok($sformatf("served id %0d", k), 32'(served[row_base + k]),
                          32'(cur_exp[k]))) main_errs++;
         end
         if (!value_ok("decode handshake", 32'({decode_start_int, decode_end_int}), 32'h0))
            main_errs++;
         if (main_errs + mon_errs != errs_before) failed++;
         $display("row %0d mask %h: %0s", r, ROW_MASK[r],
                  (main_errs + mon_errs == errs_before) ? "ok" : "FAILED");
      end
      $display("%0d tests, %0d failed, %0d errors", NUM_ROWS + 1, failed, main_errs + mon_errs);
      if (main_errs + mon_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(NUM_ROWS * 200 * CLK_PERIOD);
      $display("timeout after %0d cycles, entries did not complete", NUM_ROWS * 200);
      $display("Something failed");
      $finish;
   end

endmodule

//--- int_subsystem.f
hw/irq_pkg.sv
hw/cpu_mem_pkg.sv
hw/irq_sel_if.sv
hw/irq_edge_sync.sv
hw/irq_pending_cell.sv
hw/irq_priority.sv
hw/int_controller.sv
hw/int_subsystem.sv
dv/int_subsystem_sva.sv
dv/int_subsystem_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := int_subsystem_tb
FILELIST := int_subsystem.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
